// File: Makefile
# Verilator build and run for the reduction leaf testbench
VERILATOR ?= verilator
TOP       ?= tb_tcu_reduce
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
TRACE     ?= 0
JOBS      ?= 0

ifeq ($(TRACE),1)
TRACE_FLAGS := --trace
else
TRACE_FLAGS :=
endif

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing -j $(JOBS) $(TRACE_FLAGS) \
		--top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
+incdir+.
tcu_pkg.sv
tcu_csa_tree.sv
tcu_align_acc.sv
tcu_normalize.sv
tcu_pipe_slice.sv
tcu_reduce_top.sv
tb_tcu_reduce.sv

// File: tb_tcu_reduce.sv
// Self-checking testbench for the reduction leaf, replays the hex patterns under random stalls
`default_nettype none

`include "tcu_defines.svh"

module tb_tcu_reduce
    import tcu_pkg::*;
();

    // Each pattern holds TCU_N terms, the expected value and the expected flags
    localparam int WORDS       = `TCU_N + 2;
    localparam int NUM_PAT     = 21;
    localparam int MEM_DEPTH   = NUM_PAT * WORDS;
    localparam int AW          = $clog2(MEM_DEPTH);
    localparam int RESET_CYC   = 8;
    localparam int TIMEOUT_CYC = 40 * NUM_PAT + 100;

    logic        clk       = 1'b0;
    logic        rst_n     = 1'b0;
    logic        in_valid  = 1'b0;
    logic        in_ready;
    tcu_terms_t  in_data   = '0;
    logic        out_valid;
    logic        out_ready = 1'b0;
    tcu_result_t out_data;

    logic [31:0] pat_mem [MEM_DEPTH];

    // Shared random source for valid gaps and back-pressure
    logic [15:0] lfsr_state = 16'd87;

    // Input handshake seen at the last rising edge
    logic        in_fire    = 1'b0;
    int          cycle      = 0;
    int          send_idx   = 0;
    int          recv_idx   = 0;
    int          gap_left   = 0;

    tcu_reduce_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #20 clk = ~clk;

    // Galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic random_bit(output logic b);
        lfsr_state = lfsr_step(lfsr_state);
        b = lfsr_state[0];
    endtask

    function automatic logic [31:0] pat_word(input int pat, input int word);
        logic [AW-1:0] addr;
        addr = AW'(pat * WORDS + word);
        return pat_mem[addr];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail at time %0t: %s expected %h, actual %h",
                                $time, name, expected, actual));
        end
    endtask

    // Reset held for RESET_CYC rising edges, released on a falling edge
    initial begin
        $readmemh("tcu_reduce_patterns.hex", pat_mem);
        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        wait (recv_idx == NUM_PAT);
        // Idle tail catches a duplicated result
        repeat (4) @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

    // Watchdog sized from the pattern count
    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        abort_run($sformatf("Timeout after %0d cycles, %0d of %0d results received",
                            TIMEOUT_CYC, recv_idx, NUM_PAT));
    end

    // Source and sink both move on the falling edge
    always @(negedge clk) begin
        logic b0;
        logic b1;
        if (cycle >= RESET_CYC) begin
            random_bit(b0);
            out_ready = b0;
            // Offer taken at the last rising edge
            if (in_valid && in_fire) begin
                in_valid = 1'b0;
                send_idx = send_idx + 1;
            end
            if (!in_valid && send_idx < NUM_PAT) begin
                if (gap_left == 0) begin
                    for (int k = 0; k < `TCU_N; k++) begin
                        in_data[k] = pat_word(send_idx, k);
                    end
                    in_valid = 1'b1;
                    // Idle cycles before the next offer, 0 to 3
                    random_bit(b0);
                    random_bit(b1);
                    gap_left = int'({b1, b0});
                end else begin
                    gap_left = gap_left - 1;
                end
            end
        end
    end

    // Handshakes and results sampled at the rising edge
    always @(posedge clk) begin
        cycle   <= cycle + 1;
        in_fire <= in_valid && in_ready;
        // First edge skipped, flops may not have seen the reset yet
        if (!rst_n && cycle > 0) begin
            check_value("out_valid", 32'(out_valid), 32'd0);
            check_value("in_ready", 32'(in_ready), 32'd1);
        end
        if (rst_n && out_valid && out_ready) begin
            if (recv_idx >= NUM_PAT) begin
                abort_run("A result arrived after every pattern had been received");
            end
            check_value("out_data.value", out_data.value, pat_word(recv_idx, `TCU_N));
            check_value("out_data flags",
                        {29'd0, out_data.zero, out_data.overflow, out_data.underflow},
                        pat_word(recv_idx, `TCU_N + 1));
            recv_idx <= recv_idx + 1;
        end
    end

endmodule

`default_nettype wire

// File: tcu_align_acc.sv
// Combinational align-and-accumulate stage, TCU_N FP32 terms to sign, max exponent and magnitude
`default_nettype none

`include "tcu_defines.svh"

module tcu_align_acc
    import tcu_pkg::*;
(
    input  tcu_terms_t terms,
    output tcu_acc_t   acc
);

    localparam int MAG_W = $bits(acc_mag_t);
    localparam int SUM_W = $bits(acc_sum_t);

    // Unpacked FP32 fields
    logic [`TCU_N-1:0] op_sign;
    exp_t              op_exp [`TCU_N];
    sig_t              op_sig [`TCU_N];

    // Every term treated as normal with hidden one
    for (genvar i = 0; i < `TCU_N; i++) begin : g_fields
        assign op_sign[i] = terms[i][31];
        assign op_exp[i]  = terms[i][30:23];
        assign op_sig[i]  = {1'b1, terms[i][22:0]};
    end

    // Pairwise exponent differences, bit 8 set when row exponent is smaller
    logic [8:0]        diff_mat [`TCU_N][`TCU_N];
    logic [`TCU_N-1:0] sign_mat [`TCU_N];

    for (genvar i = 0; i < `TCU_N; i++) begin : g_row
        for (genvar j = 0; j < `TCU_N; j++) begin : g_col
            if (i == j) begin : g_diag
                assign diff_mat[i][j] = '0;
            end else begin : g_sub
                assign diff_mat[i][j] = {1'b0, op_exp[i]} - {1'b0, op_exp[j]};
            end
            assign sign_mat[i][j] = diff_mat[i][j][8];
        end
    end

    // One-hot max exponent select
    // Term i wins if all lower indices are strictly smaller
    // and no higher index is larger, so lowest index takes ties
    logic [`TCU_N-1:0] sel_exp;
    logic [`TCU_N-1:0] and_left;
    logic [`TCU_N-1:0] or_right;

    always_comb begin
        for (int i = 0; i < `TCU_N; i++) begin
            and_left[i] = 1'b1;
            or_right[i] = 1'b0;
            for (int j = 0; j < `TCU_N; j++) begin
                if (j < i) begin
                    and_left[i] = and_left[i] & sign_mat[j][i];
                end
                if (j > i) begin
                    or_right[i] = or_right[i] | sign_mat[i][j];
                end
            end
            sel_exp[i] = and_left[i] & ~or_right[i];
        end
    end

    // Max exponent and per-term shift amounts picked by the select
    // Shift is the negated difference against the winning column
    exp_t max_exp;
    exp_t shift_amt [`TCU_N];

    always_comb begin
        max_exp = '0;
        for (int j = 0; j < `TCU_N; j++) begin
            if (sel_exp[j]) begin
                max_exp = max_exp | op_exp[j];
            end
        end
        for (int i = 0; i < `TCU_N; i++) begin
            shift_amt[i] = '0;
            for (int j = 0; j < `TCU_N; j++) begin
                if (sel_exp[j]) begin
                    shift_amt[i] = shift_amt[i] | exp_t'(-diff_mat[i][j][7:0]);
                end
            end
        end
    end

    // Align to max exponent, shifted-out bits dropped, then apply sign
    sig_t  adj_sig    [`TCU_N];
    ssig_t signed_sig [`TCU_N];

    for (genvar i = 0; i < `TCU_N; i++) begin : g_align
        assign adj_sig[i]    = op_sig[i] >> shift_amt[i];
        assign signed_sig[i] = op_sign[i] ? -ssig_t'({1'b0, adj_sig[i]})
                                          : ssig_t'({1'b0, adj_sig[i]});
    end

    acc_sum_t sum;

    tcu_csa_tree u_csa_tree (
        .operands (signed_sig),
        .sum      (sum)
    );

    // Sign and magnitude of the exact sum
    logic     sum_sign;
    acc_mag_t sum_low;
    acc_mag_t abs_mag;

    assign sum_sign = sum[SUM_W-1];
    assign sum_low  = sum[MAG_W-1:0];
    assign abs_mag  = sum_sign ? -sum_low : sum_low;

    always_comb begin
        acc.sign    = sum_sign;
        acc.max_exp = max_exp;
        acc.mag     = abs_mag;
    end

endmodule

`default_nettype wire

// File: tcu_csa_tree.sv
// Carry-save reduction of TCU_N signed aligned significands into one exact sum, used by align_acc
`default_nettype none

`include "tcu_defines.svh"

module tcu_csa_tree
    import tcu_pkg::*;
(
    input  ssig_t    operands [`TCU_N],
    output acc_sum_t sum
);

    // Rows left after one level of 3:2 compression
    function automatic int next_rows(input int rows);
        return 2 * (rows / 3) + (rows % 3);
    endfunction

    // Row count entering a given level
    function automatic int rows_at(input int lvl);
        int r;
        r = `TCU_N;
        for (int k = 0; k < lvl; k++) begin
            r = next_rows(r);
        end
        return r;
    endfunction

    // Levels needed to reach two rows
    function automatic int num_levels();
        int r;
        int l;
        r = `TCU_N;
        l = 0;
        while (r > 2) begin
            r = next_rows(r);
            l++;
        end
        return l;
    endfunction

    localparam int LEVELS = num_levels();

    // Row storage per level, unused slots tied to zero
    acc_sum_t row [LEVELS+1][`TCU_N];

    // Sign extend every operand to the full sum width
    for (genvar i = 0; i < `TCU_N; i++) begin : g_init
        assign row[0][i] = {{`TCU_GROW{operands[i][`TCU_SSIG_W-1]}}, operands[i]};
    end

    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
        localparam int CUR  = rows_at(lvl);
        localparam int NGRP = CUR / 3;
        localparam int REM  = CUR % 3;
        localparam int NXT  = next_rows(CUR);

        // Full adders across all bits, carry moves one place up
        for (genvar g = 0; g < NGRP; g++) begin : g_fa
            acc_sum_t a, b, c;
            assign a = row[lvl][3*g];
            assign b = row[lvl][3*g+1];
            assign c = row[lvl][3*g+2];
            assign row[lvl+1][2*g]   = a ^ b ^ c;
            assign row[lvl+1][2*g+1] = ((a & b) | (a & c) | (b & c)) << 1;
        end

        // Leftover rows pass on untouched
        for (genvar r = 0; r < REM; r++) begin : g_pass
            assign row[lvl+1][2*NGRP+r] = row[lvl][3*NGRP+r];
        end

        for (genvar k = NXT; k < `TCU_N; k++) begin : g_unused
            assign row[lvl+1][k] = '0;
        end
    end

    // Final carry-propagate add, exact in two's complement
    assign sum = row[LEVELS][0] + row[LEVELS][1];

endmodule

`default_nettype wire

// File: tcu_defines.svh
// Term count and growth width macros for the reduction leaf, include wherever these sizes are needed
`ifndef TCU_DEFINES_SVH
`define TCU_DEFINES_SVH

// Number of FP32 terms reduced per transaction
// Must be a power of two and at least 2
`define TCU_N 4

// Growth bits needed so that the exact sum of TCU_N aligned terms cannot overflow
// Equals log2 of the term count
`define TCU_GROW ($clog2(`TCU_N))

// Width of the signed aligned significand fed to the adder tree
// One sign bit on top of the 24-bit significand
`define TCU_SSIG_W 25

// Width of the significand with the hidden one restored
`define TCU_SIG_W 24

`endif

// File: tcu_normalize.sv
// Combinational normalize and pack stage producing the FP32 result and status flags from the sum
`default_nettype none

module tcu_normalize
    import tcu_pkg::*;
(
    input  tcu_acc_t    acc,
    output tcu_result_t result
);

    localparam int MAG_W  = $bits(acc_mag_t);
    localparam int PW     = $clog2(MAG_W);
    localparam int MANT_W = 23;
    localparam int EXP_W  = 11;

    // Target bit for the leading one, the top bit of the magnitude
    localparam logic [PW-1:0] TOP_POS = PW'(MAG_W - 1);

    localparam logic signed [EXP_W-1:0] EXP_HI = 11'sd254;
    localparam logic signed [EXP_W-1:0] EXP_LO = 11'sd1;

    logic [PW-1:0]           lead_pos;
    logic                    nonzero;
    acc_mag_t                norm_mag;
    logic [MANT_W-1:0]       mant;
    logic signed [EXP_W-1:0] exp_adj;

    // Leading one search, highest set bit wins
    always_comb begin
        lead_pos = '0;
        for (int k = 0; k < MAG_W; k++) begin
            if (acc.mag[k]) begin
                lead_pos = PW'(k);
            end
        end
    end

    assign nonzero = |acc.mag;

    // Move leading one to the top bit
    // Short sums get zero fill below, long sums lose their low bits
    assign norm_mag = acc.mag << (TOP_POS - lead_pos);
    assign mant     = norm_mag[MAG_W-2 -: MANT_W];

    // New exponent is max_exp plus p minus 23, kept wide and signed
    assign exp_adj = EXP_W'(acc.max_exp) + EXP_W'(lead_pos) - EXP_W'(MANT_W);

    always_comb begin
        result.zero      = 1'b0;
        result.overflow  = 1'b0;
        result.underflow = 1'b0;
        if (!nonzero) begin
            // Exact cancellation is always positive zero
            result.value = '0;
            result.zero  = 1'b1;
        end else if (exp_adj > EXP_HI) begin
            // Saturate to infinity with sum sign
            result.value    = {acc.sign, 8'hff, {MANT_W{1'b0}}};
            result.overflow = 1'b1;
        end else if (exp_adj < EXP_LO) begin
            // Flush to signed zero
            result.value     = {acc.sign, 31'd0};
            result.underflow = 1'b1;
        end else begin
            result.value = {acc.sign, exp_adj[7:0], mant};
        end
    end

endmodule

`default_nettype wire

// File: tcu_pipe_slice.sv
// One-entry valid/ready register slice for any packed payload, used for both pipeline stages
`default_nettype none

module tcu_pipe_slice #(
    parameter type T = logic
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  up_valid,
    output logic up_ready,
    input  T     up_data,
    output logic dn_valid,
    input  wire  dn_ready,
    output T     dn_data
);

    logic valid_q;
    T     data_q;

    // Accept when empty or when the held entry leaves this cycle
    assign up_ready = ~valid_q | dn_ready;

    // Entry valid tracks accepted transfers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (up_ready) begin
            valid_q <= up_valid;
        end
    end

    // Payload loads only on a handshake
    always_ff @(posedge clk) begin
        if (up_valid && up_ready) begin
            data_q <= up_data;
        end
    end

    assign dn_valid = valid_q;
    assign dn_data  = data_q;

endmodule

`default_nettype wire

// File: tcu_pkg.sv
// Shared vector types and stage payload structs for the reduction leaf, imported by every module
`default_nettype none

`include "tcu_defines.svh"

package tcu_pkg;

    // IEEE single precision word
    typedef logic [31:0] fp32_t;

    // Biased exponent field
    typedef logic [7:0] exp_t;

    // Significand with hidden one
    typedef logic [`TCU_SIG_W-1:0] sig_t;

    // Aligned significand after sign application
    typedef logic signed [`TCU_SSIG_W-1:0] ssig_t;

    // Exact signed sum out of the CSA tree
    typedef logic signed [`TCU_SSIG_W+`TCU_GROW-1:0] acc_sum_t;

    // Magnitude of the exact sum
    typedef logic [`TCU_SIG_W+`TCU_GROW-1:0] acc_mag_t;

    // Input payload, one word per term
    typedef fp32_t [`TCU_N-1:0] tcu_terms_t;

    // Stage 1 payload handed from accumulate to normalize
    typedef struct packed {
        logic     sign;
        exp_t     max_exp;
        acc_mag_t mag;
    } tcu_acc_t;

    // Output payload with status flags
    typedef struct packed {
        fp32_t value;
        logic  zero;
        logic  overflow;
        logic  underflow;
    } tcu_result_t;

endpackage

`default_nettype wire

// File: tcu_reduce_patterns.hex
// Columns: term0 term1 term2 term3 expected_value expected_flags
// Flag bits: 2 zero, 1 overflow, 0 underflow
3F800000 3F800000 3F800000 3F800000 40800000 00000000
3FC00000 3FA00000 3F800000 3FE00000 40B00000 00000000
3F800001 3F800001 3F800001 3F800000 40800000 00000000
40000000 3F800000 3F000000 3E800000 40700000 00000000
3F800000 3F800000 3F800000 3F000001 40600000 00000000
40000000 33800000 33800000 33800000 40000000 00000000
3F000000 40000000 40400000 3F800000 40D00000 00000000
BF800000 BF800000 BF800000 BF800001 C0800000 00000000
3F800000 C0000000 BF800000 3F000000 BFC00000 00000000
3FC00000 BFC00000 40400000 C0400000 00000000 00000004
3F800008 BF800000 3F800000 BF800000 35800000 00000000
3FF00000 BFE00000 3F800000 BF800000 3E000000 00000000
40000000 BF000001 3F800000 BF800000 3FC00000 00000000
3FFFFFFF 3FFFFFFF 3FFFFFFF 3FFFFFFF 40FFFFFF 00000000
3FFFFFFF 3FFFFFFF 3FFFFFFF 3F800000 40DFFFFF 00000000
7F000000 7F000000 7F000000 7F000000 7F800000 00000002
FF000000 FF000000 FF000000 FF000000 FF800000 00000002
7F000000 7D800000 7D800000 7D800000 7F300000 00000000
00800008 80800000 00800000 80800000 00000000 00000001
80800008 00800000 80800000 00800000 80000000 00000001
01000000 80800000 00800000 80800000 00800000 00000000

// File: tcu_reduce_top.sv
// Top of the reduction leaf, accumulate, slice, normalize and slice with valid/ready at both ends
`default_nettype none

module tcu_reduce_top
    import tcu_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         in_valid,
    output logic        in_ready,
    input  tcu_terms_t  in_data,
    output logic        out_valid,
    input  wire         out_ready,
    output tcu_result_t out_data
);

    // Stage 1 combinational result and its registered copy
    tcu_acc_t    acc_comb;
    tcu_acc_t    acc_q;
    logic        acc_valid;
    logic        acc_ready;

    // Stage 2 combinational result
    tcu_result_t res_comb;

    tcu_align_acc u_align_acc (
        .terms (in_data),
        .acc   (acc_comb)
    );

    // Slice A holds the aligned sum
    tcu_pipe_slice #(
        .T (tcu_acc_t)
    ) u_slice_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .up_valid (in_valid),
        .up_ready (in_ready),
        .up_data  (acc_comb),
        .dn_valid (acc_valid),
        .dn_ready (acc_ready),
        .dn_data  (acc_q)
    );

    tcu_normalize u_normalize (
        .acc    (acc_q),
        .result (res_comb)
    );

    // Slice B holds the packed result, its ready backs up into slice A
    tcu_pipe_slice #(
        .T (tcu_result_t)
    ) u_slice_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .up_valid (acc_valid),
        .up_ready (acc_ready),
        .up_data  (res_comb),
        .dn_valid (out_valid),
        .dn_ready (out_ready),
        .dn_data  (out_data)
    );

endmodule

`default_nettype wire
